//--- sources.f
+incdir+.
ctr_pkg.sv
counter_incr.sv
beat_tally.sv
ctr_regs.sv
ctr_top.sv
ctr_assertions.sv
tb_ctr_top.sv

//--- Makefile
TOP = tb_ctr_top

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- tb_ctr_top.sv
// Testbench for the stream byte-pointer monitor.
// Drives APB transfers and random stream beats into ctr_top, keeps a
// cycle model of both counters and checks register reads against it.
// Built and run through the Makefile with Verilator.

`default_nettype none

`include "ctr_consts.svh"

module tb_ctr_top
  import ctr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam time clk_period = 100ns;
  localparam time drive_dly = 10ns;
  // Cycle budget of all tests, with generous slack in the timeout
  localparam int beats_total = 200 + 30 + 24;
  localparam int apb_total = 40;
  localparam int run_cycles = 4 + beats_total + apb_total * 6 + 20 * 4;
  localparam time timeout = 3 * run_cycles * clk_period;

  logic                 clk;
  logic                 rst;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  beat_t                beat;
  logic [ptr_width-1:0] ptr;

  int err_cnt;
  int check_cnt;
  int test_cnt;
  int test_err_base;

  // ------------------------------------------------------------------
  // Cycle model state
  // ------------------------------------------------------------------

  int m_ptr;
  int m_pkt;
  int m_init;
  int m_kept;
  int m_wraps;
  bit m_enable;
  bit m_byte_valid;
  bit m_pkt_valid;
  bit m_ptr_reinit;
  bit m_pkt_reinit;

  ctr_top dut_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .beat    (beat),
    .ptr     (ptr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Next counter value, increment rebased on init when reinit is set
  function automatic int ref_next(input int old, input bit reinit, input int init,
                                  input int kept, input int modulus);
    int base;
    base = reinit ? init : old;
    return (base + kept) % modulus;
  endfunction

  // Counters consume what stood in front of them in the cycle just ended,
  // then the tally stage and the registers take their new values
  always @(posedge clk) begin
    int next_ptr;
    if (rst) begin
      m_ptr = 0;
      m_pkt = 0;
      m_init = 0;
      m_enable = 1'b0;
      m_byte_valid = 1'b0;
      m_pkt_valid = 1'b0;
      m_ptr_reinit = 1'b0;
      m_pkt_reinit = 1'b0;
    end else begin
      if (m_byte_valid || m_ptr_reinit) begin
        next_ptr = ref_next(m_ptr, m_ptr_reinit, m_init, m_byte_valid ? m_kept : 0,
                            `CTR_BUF_BYTES);
        if (!m_ptr_reinit && next_ptr < m_ptr) begin
          m_wraps++;
        end
        m_ptr = next_ptr;
      end
      if (m_pkt_valid || m_pkt_reinit) begin
        m_pkt = ref_next(m_pkt, m_pkt_reinit, 0, m_pkt_valid ? 1 : 0, `CTR_PKT_MOD);
      end
      m_byte_valid = beat.valid && m_enable;
      m_pkt_valid = beat.valid && beat.last && m_enable;
      m_kept = $countones(beat.keep);
      // Strobes live for one cycle after the access cycle
      m_ptr_reinit = 1'b0;
      m_pkt_reinit = 1'b0;
      if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
        if (apb_req.paddr == `CTR_ADDR_CTRL) begin
          m_enable = apb_req.pwdata[0];
          m_ptr_reinit = apb_req.pwdata[1];
          m_pkt_reinit = apb_req.pwdata[2];
        end else if (apb_req.paddr == `CTR_ADDR_INIT) begin
          m_init = (apb_req.pwdata > 32'd99) ? 99 : int'(apb_req.pwdata);
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Helper tasks
  // ------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // One APB transfer, response sampled mid access cycle
  task automatic apb_xfer(input bit write, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    waits = 0;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(posedge clk);
    #drive_dly;
    apb_req.penable = 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready && waits < 4) begin
      waits++;
      @(negedge clk);
    end
    if (!apb_rsp.pready) begin
      err_cnt++;
      $display("APB transfer to address 0x%h never got pready", addr);
    end
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(posedge clk);
    #drive_dly;
    apb_req = '0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
  endtask

  task automatic reg_read_check(input logic [7:0] addr, input string name,
                                input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    check_value(name, rdata, exp);
  endtask

  // A valid beat every cycle, random keep and last
  task automatic send_beats(input int count);
    repeat (count) begin
      beat.valid = 1'b1;
      beat.keep = keep_width'($urandom());
      beat.last = ($urandom() % 4) == 0;
      @(posedge clk);
      #drive_dly;
    end
    beat = '0;
  endtask

  task automatic idle(input int cycles);
    beat = '0;
    repeat (cycles) @(posedge clk);
    #drive_dly;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          seed_ret;
    int          ptr_before;
    int          pkt_before;
    seed_ret = $urandom(32'he6be_5dcb);
    err_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    test_err_base = 0;
    m_wraps = 0;
    rst = 1'b1;
    apb_req = '0;
    beat = '0;
    repeat (4) @(posedge clk);
    #drive_dly;
    rst = 1'b0;

    reg_read_check(`CTR_ADDR_CTRL, "ctrl", 32'd0);
    reg_read_check(`CTR_ADDR_INIT, "init", 32'd0);
    reg_read_check(`CTR_ADDR_PTR, "ptr", 32'd0);
    reg_read_check(`CTR_ADDR_PKT, "pkt", 32'd0);
    apb_xfer(1'b0, 8'h10, 32'd0, rdata, err);
    check_value("pslverr", 32'(err), 32'd1);
    apb_xfer(1'b1, `CTR_ADDR_PTR, 32'd5, rdata, err);
    check_value("pslverr", 32'(err), 32'd1);
    reg_read_check(`CTR_ADDR_PTR, "ptr", 32'd0);
    finish_test("reset values and bus errors");

    reg_write(`CTR_ADDR_CTRL, 32'd1);
    repeat (4) begin
      send_beats(50);
      idle(3);
      check_value("ptr port", 32'(ptr), m_ptr);
      reg_read_check(`CTR_ADDR_PTR, "ptr", m_ptr);
      reg_read_check(`CTR_ADDR_PKT, "pkt", m_pkt);
    end
    if (m_wraps < 2) begin
      err_cnt++;
      $display("Byte pointer wrapped only %0d times in the counting test", m_wraps);
    end
    finish_test("counting with enable set");

    reg_write(`CTR_ADDR_CTRL, 32'd0);
    ptr_before = m_ptr;
    pkt_before = m_pkt;
    send_beats(30);
    idle(3);
    reg_read_check(`CTR_ADDR_PTR, "ptr", ptr_before);
    reg_read_check(`CTR_ADDR_PKT, "pkt", pkt_before);
    finish_test("beats ignored with enable clear");

    reg_write(`CTR_ADDR_INIT, 32'd42);
    reg_write(`CTR_ADDR_CTRL, 32'd2);
    reg_read_check(`CTR_ADDR_PTR, "ptr", 32'd42);
    reg_read_check(`CTR_ADDR_INIT, "init", 32'd42);
    reg_write(`CTR_ADDR_INIT, 32'd150);
    reg_read_check(`CTR_ADDR_INIT, "init", 32'd99);
    finish_test("init load and clamp");

    // Strobe lands while beats stream in every cycle
    reg_write(`CTR_ADDR_INIT, 32'd37);
    reg_write(`CTR_ADDR_CTRL, 32'd1);
    fork
      send_beats(24);
      begin
        repeat (6) @(posedge clk);
        #drive_dly;
        reg_write(`CTR_ADDR_CTRL, 32'd7);
      end
    join
    idle(3);
    reg_read_check(`CTR_ADDR_PTR, "ptr", m_ptr);
    reg_read_check(`CTR_ADDR_PKT, "pkt", m_pkt);
    finish_test("reinit during traffic");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Ends a run that hangs
  initial begin
    #(timeout);
    $display("Run did not finish within %0t, stopped by the watchdog", timeout);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : tb_ctr_top

`default_nettype wire

//--- ctr_assertions.sv
// Concurrent checks for the byte-pointer monitor, attached with bind.
// Each counter_incr instance gets range, next-value and reinit checks.
// The instance bound at the top level watches where pslverr may appear.

`default_nettype none

module ctr_assertions #(
  parameter int max_value = 1,
  localparam int value_width = $clog2(max_value + 1)
) (
  input logic                   clk,
  input logic                   rst,
  input logic                   reinit,
  input logic [value_width-1:0] initial_value,
  input logic                   incr_valid,
  input logic [value_width-1:0] value,
  input logic [value_width-1:0] value_next,
  input logic                   psel,
  input logic                   penable,
  input logic                   pslverr
);

  timeunit 1ns;
  timeprecision 1ps;

  // Counter stays inside its range
  value_in_range: assert property (@(posedge clk) disable iff (rst)
    int'(value) <= max_value)
    else $error("counter value %0d above %0d", value, max_value);

  // Register always follows the previewed next value
  value_follows_next: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> value == $past(value_next))
    else $error("counter value %0d differs from previous value_next", value);

  // Plain reinit loads the initial value
  reinit_loads_init: assert property (@(posedge clk) disable iff (rst)
    reinit && !incr_valid |=> value == $past(initial_value))
    else $error("reinit did not load initial value, got %0d", value);

  // Error only in the access phase
  pslverr_in_access: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> psel && penable)
    else $error("pslverr raised outside an APB access cycle");

endmodule : ctr_assertions

bind counter_incr ctr_assertions #(.max_value(max_value)) asrt_i (
  .clk           (clk),
  .rst           (rst),
  .reinit        (reinit),
  .initial_value (initial_value),
  .incr_valid    (incr_valid),
  .value         (value),
  .value_next    (value_next),
  .psel          (1'b0),
  .penable       (1'b0),
  .pslverr       (1'b0)
);

bind ctr_top ctr_assertions apb_asrt_i (
  .clk           (clk),
  .rst           (rst),
  .reinit        (1'b0),
  .initial_value (1'b0),
  .incr_valid    (1'b0),
  .value         (1'b0),
  .value_next    (1'b0),
  .psel          (apb_req.psel),
  .penable       (apb_req.penable),
  .pslverr       (apb_rsp.pslverr)
);

`default_nettype wire

//--- ctr_top.sv
// Top level of the stream byte-pointer monitor.
// Beats enter through the tally stage, which feeds a byte pointer
// wrapping at the buffer size and a packet counter.
// Software steers both counters and reads them back over APB.
// The byte pointer is also exported as ptr.

`default_nettype none

`include "ctr_consts.svh"

module ctr_top
  import ctr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  apb_req_t             apb_req,
  output apb_rsp_t             apb_rsp,
  input  beat_t                beat,
  output logic [ptr_width-1:0] ptr
);

  ctr_ctrl_t            ctrl;
  tally_t               tally;
  logic [pkt_width-1:0] pkt;

  // Register block
  ctr_regs regs_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .ptr     (ptr),
    .pkt     (pkt),
    .ctrl    (ctrl)
  );

  // Beat to increment conversion
  beat_tally tally_i (
    .clk    (clk),
    .rst    (rst),
    .beat   (beat),
    .enable (ctrl.enable),
    .tally  (tally)
  );

  // ------------------------------------------------------------------
  // Counters
  // ------------------------------------------------------------------

  // Byte pointer, modulus not a power of two
  counter_incr #(
    .max_value (`CTR_BUF_BYTES - 1),
    .max_incr  (`CTR_MAX_INCR)
  ) ptr_ctr_i (
    .clk           (clk),
    .rst           (rst),
    .reinit        (ctrl.ptr_reinit),
    .initial_value (ctrl.init_ptr),
    .incr_valid    (tally.byte_valid),
    .incr          (tally.byte_incr),
    .value         (ptr),
    .value_next    ()
  );

  // Packet counter, one step per last beat
  counter_incr #(
    .max_value (`CTR_PKT_MOD - 1),
    .max_incr  (1)
  ) pkt_ctr_i (
    .clk           (clk),
    .rst           (rst),
    .reinit        (ctrl.pkt_reinit),
    .initial_value ({pkt_width{1'b0}}),
    .incr_valid    (tally.pkt_valid),
    .incr          (1'b1),
    .value         (pkt),
    .value_next    ()
  );

endmodule : ctr_top

`default_nettype wire

//--- ctr_regs.sv
// APB register block of the byte-pointer monitor.
// CTRL holds enable and two reinit strobes, INIT holds the initial
// byte pointer, PTR and PKT read back the two counters.
// Every transfer takes a setup and an access cycle, with no wait states.
// Strobes show up as one-cycle pulses after the access cycle.

`default_nettype none

`include "ctr_consts.svh"

module ctr_regs
  import ctr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  apb_req_t             apb_req,
  output apb_rsp_t             apb_rsp,
  input  logic [ptr_width-1:0] ptr,
  input  logic [pkt_width-1:0] pkt,
  output ctr_ctrl_t            ctrl
);

  // ------------------------------------------------------------------
  // Transfer decode
  // ------------------------------------------------------------------

  logic access;
  logic hit_ctrl;
  logic hit_init;
  logic hit_ptr;
  logic hit_pkt;
  logic addr_ok;
  logic err;
  logic wr_en;

  // Access phase is the second cycle of a transfer
  assign access = apb_req.psel && apb_req.penable;

  assign hit_ctrl = apb_req.paddr == `CTR_ADDR_CTRL;
  assign hit_init = apb_req.paddr == `CTR_ADDR_INIT;
  assign hit_ptr  = apb_req.paddr == `CTR_ADDR_PTR;
  assign hit_pkt  = apb_req.paddr == `CTR_ADDR_PKT;
  assign addr_ok  = hit_ctrl || hit_init || hit_ptr || hit_pkt;

  // Unknown address, or a write to a read-only counter
  assign err = !addr_ok || (apb_req.pwrite && (hit_ptr || hit_pkt));

  // Writes land at the end of the access cycle
  assign wr_en = access && apb_req.pwrite && !err;

  // ------------------------------------------------------------------
  // INIT clamp
  // ------------------------------------------------------------------

  logic [ptr_width-1:0] init_wdata;

  // Values past the last buffer byte are pinned to it
  always_comb begin
    if (apb_req.pwdata > 32'(`CTR_BUF_BYTES - 1)) begin
      init_wdata = ptr_width'(`CTR_BUF_BYTES - 1);
    end else begin
      init_wdata = apb_req.pwdata[ptr_width-1:0];
    end
  end

  // ------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------

  logic                 enable_q;
  logic                 ptr_reinit_q;
  logic                 pkt_reinit_q;
  logic [ptr_width-1:0] init_ptr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      enable_q     <= 1'b0;
      ptr_reinit_q <= 1'b0;
      pkt_reinit_q <= 1'b0;
      init_ptr_q   <= '0;
    end else begin
      // Strobes last one cycle only
      ptr_reinit_q <= wr_en && hit_ctrl && apb_req.pwdata[1];
      pkt_reinit_q <= wr_en && hit_ctrl && apb_req.pwdata[2];
      if (wr_en && hit_ctrl) begin
        enable_q <= apb_req.pwdata[0];
      end
      if (wr_en && hit_init) begin
        init_ptr_q <= init_wdata;
      end
    end
  end

  assign ctrl = '{
    enable:     enable_q,
    ptr_reinit: ptr_reinit_q,
    pkt_reinit: pkt_reinit_q,
    init_ptr:   init_ptr_q
  };

  // ------------------------------------------------------------------
  // Read data and response
  // ------------------------------------------------------------------

  logic [31:0] rd_data;

  // Strobe bits read back as zero
  always_comb begin
    rd_data = '0;
    if (hit_ctrl) begin
      rd_data = 32'(enable_q);
    end else if (hit_init) begin
      rd_data = 32'(init_ptr_q);
    end else if (hit_ptr) begin
      rd_data = 32'(ptr);
    end else if (hit_pkt) begin
      rd_data = 32'(pkt);
    end
  end

  // Bus stays quiet outside a read access
  assign apb_rsp = '{
    prdata:  (access && !apb_req.pwrite) ? rd_data : 32'h0,
    pready:  access,
    pslverr: access && err
  };

endmodule : ctr_regs

`default_nettype wire

//--- beat_tally.sv
// Turns stream beats into counter increments.
// Each accepted beat yields a byte count from its keep mask and a
// packet increment on the last beat. Results are registered, so they
// appear one cycle after the beat is sampled. Nothing counts while
// enable is low.

`default_nettype none

module beat_tally
  import ctr_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  beat_t  beat,
  input  logic   enable,
  output tally_t tally
);

  // ------------------------------------------------------------------
  // Keep mask population count
  // ------------------------------------------------------------------

  logic [incr_width-1:0] kept_bytes;

  always_comb begin
    kept_bytes = '0;
    for (int i = 0; i < keep_width; i++) begin
      kept_bytes = kept_bytes + incr_width'(beat.keep[i]);
    end
  end

  // Beat is counted only while the monitor is enabled
  logic accept;

  assign accept = beat.valid && enable;

  // ------------------------------------------------------------------
  // Output registers
  // ------------------------------------------------------------------

  logic                  byte_valid_q;
  logic                  pkt_valid_q;
  logic [incr_width-1:0] byte_incr_q;

  // Empty keep mask still gives a valid zero increment
  always_ff @(posedge clk) begin
    if (rst) begin
      byte_valid_q <= 1'b0;
      pkt_valid_q  <= 1'b0;
    end else begin
      byte_valid_q <= accept;
      pkt_valid_q  <= accept && beat.last;
    end
  end

  // Byte count of the beat sampled at this edge
  always_ff @(posedge clk) begin
    byte_incr_q <= kept_bytes;
  end

  assign tally = '{
    byte_valid: byte_valid_q,
    byte_incr:  byte_incr_q,
    pkt_valid:  pkt_valid_q
  };

endmodule : beat_tally

`default_nettype wire

//--- counter_incr.sv
// Wrapping counter with a variable increment per cycle.
// The counter wraps past max_value, whether or not max_value + 1 is a
// power of two. A reinit reloads initial_value, and an increment in the
// same cycle applies on top of the initial value.
// value_next shows what value holds after the next edge.

`default_nettype none

module counter_incr #(
  // Largest counter value, inclusive
  parameter int max_value = 1,
  // Largest increment per cycle, inclusive
  parameter int max_incr = 1,
  localparam int value_width = $clog2(max_value + 1),
  localparam int incr_width = $clog2(max_incr + 1)
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   reinit,
  input  logic [value_width-1:0] initial_value,
  input  logic                   incr_valid,
  input  logic [incr_width-1:0]  incr,
  output logic [value_width-1:0] value,
  output logic [value_width-1:0] value_next
);

  // ------------------------------------------------------------------
  // Next value
  // ------------------------------------------------------------------

  localparam int max_value_p1 = max_value + 1;
  localparam bit is_pow2 = (max_value_p1 & (max_value_p1 - 1)) == 0;
  // Wide enough for the largest value plus the largest increment
  localparam int temp_width = $clog2(max_value + max_incr + 1);

  logic [value_width-1:0] base;
  logic [incr_width-1:0]  step;
  logic [temp_width-1:0]  value_temp;

  // Reinit rebases the sum on the initial value
  assign base = reinit ? initial_value : value;
  assign step = incr_valid ? incr : '0;
  assign value_temp = temp_width'(base) + temp_width'(step);

  if (is_pow2) begin : gen_pow2
    // Dropping the carry bits wraps for free
    assign value_next = value_temp[value_width-1:0];
  end else begin : gen_non_pow2
    logic [temp_width-1:0] value_wrapped;

    // Sum past the top folds back by one modulus
    assign value_wrapped = value_temp - temp_width'(max_value_p1);
    assign value_next = (value_temp > temp_width'(max_value)) ?
                        value_wrapped[value_width-1:0] :
                        value_temp[value_width-1:0];
  end

  // ------------------------------------------------------------------
  // Value register
  // ------------------------------------------------------------------

  // Holds still unless something moves it
  always_ff @(posedge clk) begin
    if (rst) begin
      value <= initial_value;
    end else if (incr_valid || reinit) begin
      value <= value_next;
    end
  end

endmodule : counter_incr

`default_nettype wire

//--- ctr_pkg.sv
// Types shared by the stream byte-pointer monitor.
// Import it in the module header of any block that carries
// stream beats, APB traffic, control or tally information.

`default_nettype none

`include "ctr_consts.svh"

package ctr_pkg;

  // Field widths derived from the buffer geometry
  localparam int ptr_width = $clog2(`CTR_BUF_BYTES);
  localparam int incr_width = $clog2(`CTR_MAX_INCR + 1);
  localparam int pkt_width = $clog2(`CTR_PKT_MOD);
  // One keep bit per byte lane
  localparam int keep_width = `CTR_MAX_INCR;

  // One beat of the input stream
  typedef struct packed {
    logic                  valid;
    logic [keep_width-1:0] keep;
    logic                  last;
  } beat_t;

  // APB request from the bus master
  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response back to the master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Register block steering of the datapath
  typedef struct packed {
    logic                 enable;
    logic                 ptr_reinit;
    logic                 pkt_reinit;
    logic [ptr_width-1:0] init_ptr;
  } ctr_ctrl_t;

  // Per-beat increments for both counters
  typedef struct packed {
    logic                  byte_valid;
    logic [incr_width-1:0] byte_incr;
    logic                  pkt_valid;
  } tally_t;

endpackage : ctr_pkg

`default_nettype wire

//--- ctr_consts.svh
// Constants shared by the stream byte-pointer monitor.
// Holds the buffer geometry, the per-beat increment limit,
// the packet counter modulus and the APB register map.
// Include it wherever one of these values is needed.

`ifndef CTR_CONSTS_SVH
`define CTR_CONSTS_SVH

// Circular buffer size in bytes, also the byte pointer modulus
`define CTR_BUF_BYTES 100

// Largest number of bytes a single beat can carry
`define CTR_MAX_INCR 4

// Packet counter wraps at this count
`define CTR_PKT_MOD 256

// APB register byte offsets
`define CTR_ADDR_CTRL 8'h00
`define CTR_ADDR_INIT 8'h04
`define CTR_ADDR_PTR 8'h08
`define CTR_ADDR_PKT 8'h0C

`endif
